// File: all.f
rtl/lstm_pkg.sv
rtl/fix_mul.sv
rtl/vec_mul.sv
rtl/add_tree.sv
rtl/gate_sum.sv
rtl/gate_preact.sv
bench/gate_preact_chk.sv
bench/gate_preact_tb.sv

// File: bench/gate_preact_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gate_preact_tb
	import lstm_pkg::*;
();

	// stimulus kinds
	localparam int k_small = 0;
	localparam int k_lane_sat = 1;
	localparam int k_out_sat = 2;
	localparam int k_trunc = 3;

	localparam int rst_cycles = 3;
	localparam int n_b2b = 40;
	localparam int n_gap = 40;
	localparam int n_lsat = 12;
	localparam int n_osat = 8;
	localparam int n_trunc = 16;
	localparam int n_mid = 6;
	localparam int rst_mid = 2;
	localparam int n_post = 12;
	localparam int stim_cycles = rst_cycles + n_b2b + n_gap + n_lsat + n_osat + n_trunc +
		n_mid + rst_mid + n_post;
	localparam int cyc_limit = stim_cycles + pipe_lat + 20;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	logic [x_lanes*data_w-1:0] x_vec;
	logic [x_lanes*data_w-1:0] wx_vec;
	logic [h_lanes*data_w-1:0] h_vec;
	logic [h_lanes*data_w-1:0] wh_vec;
	data_t bias;
	data_t preact;
	logic out_valid;

	logic [31:0] rng = 32'hec97;
	int cyc = 0;
	int due_q [$];
	data_t val_q [$];
	int data_errs = 0;
	int flag_errs = 0;
	int miss_errs = 0;

	gate_preact dut0 (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.x_vec     (x_vec),
		.wx_vec    (wx_vec),
		.h_vec     (h_vec),
		.wh_vec    (wh_vec),
		.bias      (bias),
		.preact    (preact),
		.out_valid (out_valid)
	);

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v ^= v << 13;
		v ^= v >> 17;
		v ^= v << 5;
		return v;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// top bit of the next draw
	function automatic logic rand_bit();
		logic [31:0] r;
		r = next_rand();
		return r[31];
	endfunction

	function automatic data_t clamp(input longint v);
		if (v > longint'(data_max))
			return data_max;
		if (v < longint'(data_min))
			return data_min;
		return data_t'(v);
	endfunction

	// Q8.8 product, floored then clipped
	function automatic data_t lane_product(input data_t a, input data_t b);
		int p;
		p = int'(a) * int'(b);
		p = p >>> frac_w;
		return clamp(longint'(p));
	endfunction

	function automatic data_t expected_preact(
		input logic [x_lanes*data_w-1:0] xv,
		input logic [x_lanes*data_w-1:0] wxv,
		input logic [h_lanes*data_w-1:0] hv,
		input logic [h_lanes*data_w-1:0] whv,
		input data_t b
	);
		longint total;
		total = longint'(b);
		for (int i = 0; i < x_lanes; i++)
			total += longint'(lane_product(xv[i*data_w +: data_w], wxv[i*data_w +: data_w]));
		for (int i = 0; i < h_lanes; i++)
			total += longint'(lane_product(hv[i*data_w +: data_w], whv[i*data_w +: data_w]));
		return clamp(total);
	endfunction

	function automatic data_t pick_val(input int kind, input bit neg, input bit is_wgt);
		logic [31:0] r;
		data_t v;
		r = next_rand();
		case (kind)
			k_small: v = {{6{r[9]}}, r[9:0]};   // about +-2.0
			k_lane_sat: begin
				v = 16'h7e00 | r[8:0];
				if (r[31])
					v = -v;
			end
			k_out_sat: begin
				v = 16'h0400 + r[9:0];
				if (neg && is_wgt)
					v = -v;   // negative weights and bias
			end
			k_trunc: v = {{6{r[9]}}, r[9:0]} | 16'h0001;   // odd low bit
			default: v = '0;
		endcase
		return v;
	endfunction

	task automatic fill_set(input int kind);
		bit neg;
		neg = rand_bit();
		for (int i = 0; i < x_lanes; i++) begin
			x_vec[i*data_w +: data_w] = pick_val(kind, neg, 1'b0);
			wx_vec[i*data_w +: data_w] = pick_val(kind, neg, 1'b1);
		end
		for (int i = 0; i < h_lanes; i++) begin
			h_vec[i*data_w +: data_w] = pick_val(kind, neg, 1'b0);
			wh_vec[i*data_w +: data_w] = pick_val(kind, neg, 1'b1);
		end
		bias = pick_val(kind, neg, 1'b1);
	endtask

	task automatic drive_cycle(input logic v, input logic rst_n, input int kind);
		@(posedge clk);
		#1;
		reset = rst_n;
		in_valid = v;
		fill_set(kind);
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h got %h (cycle %0d)", name, exp, act, cyc);
			data_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %h got %h (cycle %0d)", name, exp, act, cyc);
			flag_errs++;
		end
	endtask

	// outputs and inputs are both settled mid cycle
	always @(negedge clk) begin
		if (due_q.size() != 0 && due_q[0] == cyc) begin
			if (out_valid !== 1'b1) begin
				$display("result due in cycle %0d did not arrive, out_valid stayed low", cyc);
				miss_errs++;
			end else begin
				check_data("preact", val_q[0], preact);
			end
			void'(due_q.pop_front());
			void'(val_q.pop_front());
		end else begin
			check_flag("out_valid", 1'b0, out_valid);
		end
		if (!reset) begin
			due_q.delete();   // sets in flight are dropped
			val_q.delete();
		end else if (in_valid) begin
			due_q.push_back(cyc + pipe_lat);
			val_q.push_back(expected_preact(x_vec, wx_vec, h_vec, wh_vec, bias));
		end
	end

	always @(posedge clk) begin
		if (cyc >= cyc_limit) begin
			$display("timeout at cycle %0d with %0d results still pending", cyc, due_q.size());
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int total_errs;
		reset = 1'b0;
		in_valid = 1'b0;
		x_vec = '0;
		wx_vec = '0;
		h_vec = '0;
		wh_vec = '0;
		bias = '0;
		repeat (rst_cycles - 1) drive_cycle(1'b0, 1'b0, k_small);
		repeat (n_b2b) drive_cycle(1'b1, 1'b1, k_small);
		repeat (n_gap) drive_cycle(rand_bit(), 1'b1, k_small);
		repeat (n_lsat) drive_cycle(1'b1, 1'b1, k_lane_sat);
		repeat (n_osat) drive_cycle(1'b1, 1'b1, k_out_sat);
		repeat (n_trunc) drive_cycle(1'b1, 1'b1, k_trunc);
		repeat (n_mid) drive_cycle(1'b1, 1'b1, k_small);
		repeat (rst_mid) drive_cycle(1'b1, 1'b0, k_small);   // reset with sets in flight
		drive_cycle(1'b0, 1'b1, k_small);
		repeat (n_post - 2) drive_cycle(rand_bit(), 1'b1, k_small);
		drive_cycle(1'b0, 1'b1, k_small);
		while (due_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		total_errs = data_errs + flag_errs + miss_errs + int'(dut0.chk0.fail_cnt);
		$display("errors: data %0d, flag %0d, missing %0d, assertion %0d",
			data_errs, flag_errs, miss_errs, dut0.chk0.fail_cnt);
		if (total_errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/gate_preact_chk.sv
`timescale 1ns/1ps
`default_nettype none

module gate_preact_chk
	import lstm_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire out_valid,
	input wire data_t preact
);

	int unsigned fail_cnt = 0;

	// strobe is cleared on the edge after reset is seen
	a_quiet_in_reset: assert property (@(posedge clk) !reset |=> !out_valid)
		else begin
			fail_cnt++;
			$error("out_valid high after a reset edge");
		end

	a_latency: assert property (@(posedge clk) disable iff (!reset)
		in_valid |-> ##pipe_lat out_valid)
		else begin
			fail_cnt++;
			$error("no out_valid %0d cycles after in_valid", pipe_lat);
		end

	a_known_result: assert property (@(posedge clk) disable iff (!reset)
		out_valid |-> !$isunknown(preact))
		else begin
			fail_cnt++;
			$error("preact has unknown bits while out_valid is high");
		end

endmodule

bind gate_preact gate_preact_chk chk0 (.*);

`default_nettype wire

// File: rtl/gate_preact.sv
`timescale 1ns/1ps
`default_nettype none

module gate_preact
	import lstm_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire [x_lanes*data_w-1:0] x_vec,
	input wire [x_lanes*data_w-1:0] wx_vec,
	input wire [h_lanes*data_w-1:0] h_vec,
	input wire [h_lanes*data_w-1:0] wh_vec,
	input wire data_t bias,
	output data_t preact,
	output logic out_valid
);

	logic [x_lanes*data_w-1:0] x_prod;
	logic x_prod_valid;
	logic [h_lanes*data_w-1:0] h_prod;
	logic h_prod_valid;
	acc_t x_sum;
	logic x_sum_valid;
	acc_t h_sum;

	vec_mul #(
		.lanes (x_lanes)
	) vec_mul_x (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.vec        (x_vec),
		.weights    (wx_vec),
		.prod       (x_prod),
		.prod_valid (x_prod_valid)
	);

	vec_mul #(
		.lanes (h_lanes)
	) vec_mul_h (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.vec        (h_vec),
		.weights    (wh_vec),
		.prod       (h_prod),
		.prod_valid (h_prod_valid)
	);

	add_tree #(
		.lanes (x_lanes)
	) add_tree_x (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (x_prod_valid),
		.prod      (x_prod),
		.sum       (x_sum),
		.sum_valid (x_sum_valid)
	);

	// h result is one cycle ahead of x by construction
	add_tree #(
		.lanes (h_lanes)
	) add_tree_h (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (h_prod_valid),
		.prod      (h_prod),
		.sum       (h_sum),
		.sum_valid ()
	);

	gate_sum gate_sum0 (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.bias      (bias),
		.x_sum     (x_sum),
		.x_valid   (x_sum_valid),
		.h_sum     (h_sum),
		.preact    (preact),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

// File: rtl/gate_sum.sv
`timescale 1ns/1ps
`default_nettype none

module gate_sum
	import lstm_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire data_t bias,
	input wire acc_t x_sum,
	input wire x_valid,
	input wire acc_t h_sum,
	output data_t preact,
	output logic out_valid
);

	// capture, multiplier and x tree stages
	localparam int bias_stages = pipe_lat - 1;
	// h tree is shorter by this many levels
	localparam int h_pad = x_levels - h_levels;

	data_t bias_q [bias_stages];
	acc_t h_q [h_pad];
	acc_t total;
	data_t sat;

	// first stage loads with the set, later stages shift every cycle
	always_ff @(posedge clk) begin
		if (in_valid)
			bias_q[0] <= bias;
		for (int i = 1; i < bias_stages; i++)
			bias_q[i] <= bias_q[i-1];
	end

	always_ff @(posedge clk) begin
		h_q[0] <= h_sum;
		for (int i = 1; i < h_pad; i++)
			h_q[i] <= h_q[i-1];
	end

	assign total = x_sum + h_q[h_pad-1] + acc_t'(bias_q[bias_stages-1]);

	always_comb begin
		if (total > acc_t'(data_max))
			sat = data_max;
		else if (total < acc_t'(data_min))
			sat = data_min;
		else
			sat = data_t'(total);
	end

	always_ff @(posedge clk) begin
		if (x_valid)
			preact <= sat;
	end

	always_ff @(posedge clk) begin
		if (!reset)
			out_valid <= 1'b0;
		else
			out_valid <= x_valid;   // single cycle per set
	end

endmodule

`default_nettype wire

// File: rtl/add_tree.sv
`timescale 1ns/1ps
`default_nettype none

// lanes must be a power of two, at least 2
module add_tree
	import lstm_pkg::*;
#(
	parameter int lanes = 16
)(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire [lanes*data_w-1:0] prod,
	output acc_t sum,
	output logic sum_valid
);

	localparam int levels = $clog2(lanes);

	acc_t leaf [lanes];
	logic [levels-1:0] vld;

	// products widened before the first add
	always_comb begin
		for (int i = 0; i < lanes; i++)
			leaf[i] = acc_t'(data_t'(prod[i*data_w +: data_w]));
	end

	// one register per halving, no saturation needed at acc_w
	for (genvar l = 0; l < levels; l++) begin : g_lvl
		localparam int n = lanes >> (l + 1);

		acc_t s [n];

		if (l == 0) begin : g_first
			always_ff @(posedge clk) begin
				for (int k = 0; k < n; k++)
					s[k] <= leaf[2*k] + leaf[2*k+1];
			end
		end else begin : g_next
			always_ff @(posedge clk) begin
				for (int k = 0; k < n; k++)
					s[k] <= g_lvl[l-1].s[2*k] + g_lvl[l-1].s[2*k+1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			vld <= '0;
		end else begin
			vld[0] <= in_valid;
			for (int i = 1; i < levels; i++)
				vld[i] <= vld[i-1];
		end
	end

	assign sum = g_lvl[levels-1].s[0];   // root of the tree
	assign sum_valid = vld[levels-1];

endmodule

`default_nettype wire

// File: rtl/vec_mul.sv
`timescale 1ns/1ps
`default_nettype none

module vec_mul
	import lstm_pkg::*;
#(
	parameter int lanes = 16
)(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire [lanes*data_w-1:0] vec,
	input wire [lanes*data_w-1:0] weights,
	output logic [lanes*data_w-1:0] prod,
	output logic prod_valid
);

	logic [lanes*data_w-1:0] vec_q;
	logic [lanes*data_w-1:0] wgt_q;
	logic [1:0] vld;   // capture stage, multiplier stage

	// operands held between sets
	always_ff @(posedge clk) begin
		if (in_valid) begin
			vec_q <= vec;
			wgt_q <= weights;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset)
			vld <= '0;
		else
			vld <= {vld[0], in_valid};
	end

	assign prod_valid = vld[1];   // lines up with the registered products

	for (genvar i = 0; i < lanes; i++) begin : g_lane
		fix_mul mul0 (
			.clk (clk),
			.a   (vec_q[i*data_w +: data_w]),
			.b   (wgt_q[i*data_w +: data_w]),
			.c   (prod[i*data_w +: data_w])
		);
	end

endmodule

`default_nettype wire

// File: rtl/fix_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fix_mul
	import lstm_pkg::*;
(
	input wire clk,
	input wire data_t a,
	input wire data_t b,
	output data_t c
);

	localparam int prod_w = 2 * data_w;
	localparam int keep_w = prod_w - frac_w;   // integer part plus 8 fraction bits

	logic signed [prod_w-1:0] full;
	logic signed [keep_w-1:0] shifted;
	logic fits;
	data_t sat;

	assign full = a * b;

	// dropping the low bits of a two's complement value floors it
	assign shifted = full[prod_w-1:frac_w];

	// in range when every bit above the data_t sign bit repeats it
	assign fits = (shifted[keep_w-1:data_w-1] == '0) ||
		(shifted[keep_w-1:data_w-1] == '1);

	always_comb begin
		if (fits)
			sat = shifted[data_w-1:0];
		else if (shifted[keep_w-1])
			sat = data_min;
		else
			sat = data_max;
	end

	always_ff @(posedge clk) begin
		c <= sat;
	end

endmodule

`default_nettype wire

// File: rtl/lstm_pkg.sv
`default_nettype none

package lstm_pkg;

	// Q8.8 element format
	localparam int data_w = 16;
	localparam int frac_w = 8;

	// vector lengths
	localparam int x_lanes = 16;
	localparam int h_lanes = 8;

	// 24 saturated products plus bias need 21 bits, one spare
	localparam int acc_w = 22;

	// adder levels per tree
	localparam int x_levels = 4;
	localparam int h_levels = 3;

	// sampled in_valid to out_valid
	localparam int pipe_lat = 7;

	typedef logic signed [data_w-1:0] data_t;
	typedef logic signed [acc_w-1:0] acc_t;   // same binary point as data_t

	localparam data_t data_max = 16'sh7fff;
	localparam data_t data_min = 16'sh8000;

endpackage

`default_nettype wire
